// File: compile.f
hdl/FetchPkg.sv
hdl/FetchOpIf.sv
hdl/BranchSelector.sv
hdl/BranchPredictor.sv
hdl/FetchTable.sv
hdl/PCFile.sv
hdl/IFetch.sv
verif/ClockGen.sv
verif/IFetch_chk.sv
verif/IFetchTb.sv

// File: Bender.yml
package:
  name: ifetch

sources:
  - files:
      - hdl/FetchPkg.sv
      - hdl/FetchOpIf.sv
      - hdl/BranchSelector.sv
      - hdl/BranchPredictor.sv
      - hdl/FetchTable.sv
      - hdl/PCFile.sv
      - hdl/IFetch.sv
  - target: test
    files:
      - verif/ClockGen.sv
      - verif/IFetch_chk.sv
      - verif/IFetchTb.sv

// File: verif/IFetchTb.sv
`timescale 1ns/1ps

module IFetchTb;

    localparam int NUM_BRANCH_PROVS = 3;
    localparam int BTB_ENTRIES = 16;
    localparam int NUM_PC_READ = 2;
    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam int NUM_TESTS = 6;
    localparam int CLK_PERIOD = 100;
    localparam logic [31:0] WORD_KEY = 32'h5A3C_96E1;

    logic clk;
    logic rst;
    logic en;
    logic irqPending;
    FetchPkg::BranchProv_t branches[NUM_BRANCH_PROVS-1:0];
    FetchPkg::SqN_t robCurSqN;
    FetchPkg::FetchID_t robComFetchID;
    FetchPkg::DecodeBranch_t decBranch;
    FetchPkg::BTUpdate_t btUpdate;
    logic [127:0] imemData;
    logic ready;
    FetchPkg::FetchID_t pcReadAddr[NUM_PC_READ-1:0];
    logic branchMispr;
    logic imemReq;
    logic [31:0] imemAddr;
    FetchPkg::FetchBundle_t outBundle;
    FetchPkg::PCFileEntry_t pcReadData[NUM_PC_READ-1:0];

    FetchPkg::FetchBundle_t accepted[$];
    FetchPkg::FetchID_t lastAccID;
    FetchPkg::FetchID_t baseID;
    logic memReqQ;
    logic [31:0] memAddrQ;
    logic freezeCom;
    logic randomReady;
    int misprCount;
    string testName;
    int checks;
    int errors;
    int testErrors;

    ClockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clkGen (.clk(clk), .rst(rst));

    IFetch #(
        .NUM_BRANCH_PROVS(NUM_BRANCH_PROVS),
        .BTB_ENTRIES(BTB_ENTRIES),
        .NUM_PC_READ(NUM_PC_READ),
        .RESET_PC(RESET_PC)
    ) u_dut (
        .clk(clk), .rst(rst), .en(en), .irqPending(irqPending),
        .branches(branches), .robCurSqN(robCurSqN), .robComFetchID(robComFetchID),
        .decBranch(decBranch), .btUpdate(btUpdate), .imemData(imemData),
        .ready(ready), .pcReadAddr(pcReadAddr), .branchMispr(branchMispr),
        .imemReq(imemReq), .imemAddr(imemAddr), .outBundle(outBundle),
        .pcReadData(pcReadData)
    );

    // each word holds its own byte address, scrambled
    function automatic logic [127:0] blockWords(input logic [31:0] addr);
        logic [127:0] w;
        for (int i = 0; i < 4; i++) begin
            w[i*32 +: 32] = (addr + 32'(4 * i)) ^ WORD_KEY;
        end
        return w;
    endfunction

    // block 0x3000 branches to 0x2044, then the blocks fall through
    function automatic logic [31:0] walkPC(input int i);
        return (i == 0) ? 32'h0000_3000 : 32'h0000_2030 + 32'(16 * i);
    endfunction

    function automatic logic [31:0] walkTarget(input int i);
        return (i == 0) ? 32'h0000_2044 : walkPC(i) + 32'd16;
    endfunction

    task automatic expectEq(input string what, input logic [127:0] expected,
                            input logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Error %s %s: expected %0h actual %0h", testName, what, expected, actual);
            errors++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrors = errors;
    endtask

    task automatic endTest();
        $display("test %-12s %s", testName, (errors == testErrors) ? "ok" : "FAILED");
    endtask

    task automatic waitBundles(input int n, input int maxCycles);
        int waited;
        waited = 0;
        while (accepted.size() < n && waited < maxCycles) begin
            @(negedge clk);
            waited++;
        end
        if (accepted.size() < n) begin
            $display("%s: only %0d of %0d bundles arrived in %0d cycles",
                     testName, accepted.size(), n, maxCycles);
            errors++;
        end
    endtask

    // stop fetching and let the output stage empty
    task automatic drain();
        @(negedge clk);
        en = 1'b0;
        randomReady = 1'b0;
        ready = 1'b1;
        repeat (8) @(negedge clk);
        accepted.delete();
    endtask

    task automatic decodeRedirect(input FetchPkg::FetchID_t id, input logic [31:0] dst,
                                  input logic wfi);
        decBranch = '{taken: 1'b1, fetchID: id, dstPC: dst, wfi: wfi};
        @(negedge clk);
        decBranch = '0;
    endtask

    // consumer side, sampled where the outputs are settled
    always @(posedge clk) begin
        if (!rst) begin
            memReqQ <= imemReq;
            memAddrQ <= imemAddr;
            if (outBundle.valid && ready) begin
                accepted.push_back(outBundle);
                lastAccID <= outBundle.fetchID;
            end
            if (branchMispr) begin
                misprCount++;
            end
        end
    end

    // memory, commit and ready, all driven on the falling edge
    initial begin
        void'($urandom(4));
        forever begin
            @(negedge clk);
            imemData = memReqQ ? blockWords(memAddrQ) : '0;
            if (!freezeCom) begin
                robComFetchID = lastAccID;
            end
            if (randomReady) begin
                ready = 1'($urandom);
            end
        end
    end

    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", NUM_TESTS * 400);
        $display("Checks failed");
        $finish;
    end

    initial begin
        en = 1'b1;
        irqPending = 1'b0;
        branches = '{default: '0};
        robCurSqN = '0;
        robComFetchID = '0;
        decBranch = '0;
        btUpdate = '0;
        imemData = '0;
        ready = 1'b1;
        pcReadAddr = '{default: '0};
        lastAccID = '0;
        memReqQ = 1'b0;
        memAddrQ = '0;
        freezeCom = 1'b0;
        randomReady = 1'b0;
        misprCount = 0;
        checks = 0;
        errors = 0;

        startTest("seqFetch");
        wait (!rst);
        waitBundles(6, 100);
        for (int i = 0; i < 6 && i < accepted.size(); i++) begin
            expectEq("pc", RESET_PC + 32'(16 * i), accepted[i].pc);
            expectEq("fetchID", i, accepted[i].fetchID);
            expectEq("instrs", blockWords(RESET_PC + 32'(16 * i)), accepted[i].instrs);
            expectEq("lastValid", 3, accepted[i].lastValid);
            expectEq("predTaken", 0, accepted[i].predTaken);
        end
        endTest();

        startTest("btbPredict");
        drain();
        // taken branch in slot 2 of block 0x3000
        btUpdate = '{valid: 1'b1, srcPC: 32'h0000_3008, dstPC: 32'h0000_2044};
        @(negedge clk);
        btUpdate = '0;
        decodeRedirect(robComFetchID, 32'h0000_3000, 1'b0);
        en = 1'b1;
        waitBundles(2, 50);
        if (accepted.size() >= 2) begin
            expectEq("pc", 32'h3000, accepted[0].pc);
            expectEq("predTaken", 1, accepted[0].predTaken);
            expectEq("predTarget", 32'h2044, accepted[0].predTarget);
            expectEq("lastValid", 2, accepted[0].lastValid);
            expectEq("next pc", 32'h2040, accepted[1].pc);
        end
        endTest();

        startTest("oldestBranch");
        drain();
        baseID = robComFetchID;
        misprCount = 0;
        robCurSqN = 6'd60;
        // provider 0 is older once the sqN wrap is taken into account
        branches[0] = '{taken: 1'b1, sqN: 6'd62,
                        fetchID: FetchPkg::FetchID_t'(baseID + 1), dstPC: 32'h5008};
        branches[1] = '{taken: 1'b1, sqN: 6'd5,
                        fetchID: FetchPkg::FetchID_t'(baseID + 3), dstPC: 32'h4010};
        @(negedge clk);
        branches = '{default: '0};
        en = 1'b1;
        waitBundles(1, 50);
        if (accepted.size() >= 1) begin
            expectEq("pc", 32'h5000, accepted[0].pc);
            expectEq("fetchID", FetchPkg::FetchID_t'(baseID + 2), accepted[0].fetchID);
        end
        drain();
        baseID = robComFetchID;
        decodeRedirect(baseID, 32'h0000_600C, 1'b0);
        en = 1'b1;
        waitBundles(1, 50);
        if (accepted.size() >= 1) begin
            expectEq("decode pc", 32'h6000, accepted[0].pc);
            expectEq("decode fetchID", FetchPkg::FetchID_t'(baseID + 1), accepted[0].fetchID);
        end
        expectEq("mispr pulses", 1, misprCount);
        endTest();

        startTest("windowStall");
        drain();
        freezeCom = 1'b1;
        baseID = robComFetchID;
        decodeRedirect(baseID, 32'h0000_7000, 1'b0);
        randomReady = 1'b1;
        en = 1'b1;
        waitBundles(14, 300);
        repeat (30) @(negedge clk);
        expectEq("bundles in frozen window", 14, accepted.size());
        freezeCom = 1'b0;
        waitBundles(40, 600);
        for (int i = 0; i < 40 && i < accepted.size(); i++) begin
            expectEq("pc", 32'h7000 + 32'(16 * i), accepted[i].pc);
            expectEq("fetchID", FetchPkg::FetchID_t'(baseID + 1 + i), accepted[i].fetchID);
            expectEq("instrs", blockWords(32'h7000 + 32'(16 * i)), accepted[i].instrs);
        end
        endTest();

        startTest("wfiInterrupt");
        drain();
        decodeRedirect(robComFetchID, 32'h0000_8000, 1'b1);
        en = 1'b1;
        repeat (20) @(negedge clk);
        expectEq("bundles while waiting", 0, accepted.size());
        irqPending = 1'b1;
        repeat (3) @(negedge clk);
        irqPending = 1'b0;
        repeat (20) @(negedge clk);
        expectEq("interrupt bundles", 1, accepted.size());
        if (accepted.size() >= 1) begin
            expectEq("fault", FetchPkg::FF_INTERRUPT, accepted[0].fault);
            expectEq("pc", 32'h8000, accepted[0].pc);
        end
        baseID = robComFetchID;
        branches[0] = '{taken: 1'b1, sqN: robCurSqN, fetchID: baseID, dstPC: 32'h9000};
        @(negedge clk);
        branches = '{default: '0};
        accepted.delete();
        waitBundles(1, 50);
        if (accepted.size() >= 1) begin
            expectEq("pc after flush", 32'h9000, accepted[0].pc);
            expectEq("fault after flush", FetchPkg::FF_NONE, accepted[0].fault);
        end
        endTest();

        startTest("pcFile");
        drain();
        decodeRedirect(robComFetchID, 32'h0000_3000, 1'b0);
        en = 1'b1;
        waitBundles(4, 50);
        en = 1'b0;
        if (accepted.size() >= 4) begin
            for (int i = 0; i < 4; i++) begin
                expectEq("bundle pc", walkPC(i), accepted[i].pc);
                expectEq("bundle predTarget", walkTarget(i), accepted[i].predTarget);
            end
            for (int i = 0; i < 4; i++) begin
                pcReadAddr[0] = accepted[i].fetchID;
                pcReadAddr[1] = accepted[3 - i].fetchID;
                @(posedge clk);
                expectEq("port0 blockPC", walkPC(i), pcReadData[0].blockPC);
                expectEq("port0 predTarget", walkTarget(i), pcReadData[0].predTarget);
                expectEq("port1 blockPC", walkPC(3 - i), pcReadData[1].blockPC);
                expectEq("port1 predTarget", walkTarget(3 - i), pcReadData[1].predTarget);
                @(negedge clk);
            end
        end
        endTest();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 NUM_TESTS, checks, errors, u_dut.u_chk.failCount);
        if (errors == 0 && u_dut.u_chk.failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verif/IFetch_chk.sv
`timescale 1ns/1ps

module IFetchChk #(
    parameter int NUM_BRANCH_PROVS = 3
) (
    input logic clk,
    input logic rst,
    input logic ready,
    input logic imemReq,
    input logic [31:0] imemAddr,
    input logic branchMispr,
    input logic redirect,
    input logic [31:0] redirectPC,
    input FetchPkg::BranchProv_t branches[NUM_BRANCH_PROVS-1:0],
    input FetchPkg::FetchBundle_t outBundle
);

    int failCount;
    logic anyTaken;

    initial failCount = 0;

    // any execution provider reporting a taken branch
    always_comb begin
        anyTaken = 1'b0;
        for (int i = 0; i < NUM_BRANCH_PROVS; i++) begin
            anyTaken = anyTaken | branches[i].taken;
        end
    end

    // consumer stalls, so the bundle must not move
    heldStable: assert property (@(posedge clk) disable iff (rst)
        outBundle.valid && !ready && !redirect |=> $stable(outBundle))
        else begin
            $error("output bundle changed while ready was low");
            failCount++;
        end

    resetQuiet: assert property (@(posedge clk)
        rst |=> !outBundle.valid && !branchMispr)
        else begin
            $error("outputs active right after reset");
            failCount++;
        end

    // first fetch after a flush goes to the redirect block
    reqAfterRedirect: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !imemReq || imemAddr == {$past(redirectPC[31:4]), 4'b0})
        else begin
            $error("first request after a redirect missed the redirect block");
            failCount++;
        end

    // one cycle from the branch report to the pulse and the flush
    misprWithRedirect: assert property (@(posedge clk) disable iff (rst)
        (branchMispr && redirect) == $past(anyTaken))
        else begin
            $error("mispredict pulse and execute redirect out of step");
            failCount++;
        end

endmodule

bind IFetch IFetchChk #(.NUM_BRANCH_PROVS(NUM_BRANCH_PROVS)) u_chk (
    .clk(clk),
    .rst(rst),
    .ready(ready),
    .imemReq(imemReq),
    .imemAddr(imemAddr),
    .branchMispr(branchMispr),
    .redirect(redirect),
    .redirectPC(redirectPC),
    .branches(branches),
    .outBundle(outBundle)
);

// File: verif/ClockGen.sv
`timescale 1ns/1ps

module ClockGen #(
    parameter int PERIOD = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: hdl/IFetch.sv
`timescale 1ns/1ps

module IFetch #(
    parameter int NUM_BRANCH_PROVS = 3,
    parameter int BTB_ENTRIES = 16,
    parameter int NUM_PC_READ = 2,
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic irqPending,
    input  FetchPkg::BranchProv_t branches[NUM_BRANCH_PROVS-1:0],
    input  FetchPkg::SqN_t robCurSqN,
    input  FetchPkg::FetchID_t robComFetchID,
    input  FetchPkg::DecodeBranch_t decBranch,
    input  FetchPkg::BTUpdate_t btUpdate,
    input  logic [FetchPkg::BLOCK_INSTRS*32-1:0] imemData,
    input  logic ready,
    input  FetchPkg::FetchID_t pcReadAddr[NUM_PC_READ-1:0],
    output logic branchMispr,
    output logic imemReq,
    output logic [31:0] imemAddr,
    output FetchPkg::FetchBundle_t outBundle,
    output FetchPkg::PCFileEntry_t pcReadData[NUM_PC_READ-1:0]
);

    FetchPkg::BranchProv_t selBranch;
    FetchPkg::FetchState_t state;
    logic redirect;
    FetchPkg::FetchID_t redirectFetchID;
    logic [31:0] redirectPC;
    logic stall;
    logic [31:0] bpPC;
    logic bpPredTaken;
    logic [31:0] bpPredTarget;
    FetchPkg::FetchOff_t bpLastValid;
    logic pcfWrite;
    FetchPkg::FetchID_t pcfAddr;
    FetchPkg::PCFileEntry_t pcfData;

    FetchOpIf fetchOp();

    BranchSelector #(.NUM_BRANCH_PROVS(NUM_BRANCH_PROVS)) u_branchSel (
        .clk(clk),
        .rst(rst),
        .branches(branches),
        .robCurSqN(robCurSqN),
        .selBranch(selBranch),
        .mispr(branchMispr)
    );

    // execute redirect wins over decode
    assign redirect = selBranch.taken || decBranch.taken;
    assign redirectFetchID = selBranch.taken ? selBranch.fetchID : decBranch.fetchID;
    assign redirectPC = selBranch.taken ? selBranch.dstPC : decBranch.dstPC;

    BranchPredictor #(.BTB_ENTRIES(BTB_ENTRIES), .RESET_PC(RESET_PC)) u_predictor (
        .clk(clk),
        .rst(rst),
        .advance(fetchOp.valid),
        .redirect(redirect),
        .redirectPC(redirectPC),
        .btUpdate(btUpdate),
        .pc(bpPC),
        .predTaken(bpPredTaken),
        .predTarget(bpPredTarget),
        .lastValid(bpLastValid)
    );

    assign fetchOp.valid = en && state == FetchPkg::FS_RUN && !stall && !redirect;
    assign fetchOp.pc = bpPC;
    assign fetchOp.fault = irqPending ? FetchPkg::FF_INTERRUPT : FetchPkg::FF_NONE;
    assign fetchOp.lastValid = bpLastValid;
    assign fetchOp.predTaken = bpPredTaken;
    assign fetchOp.predTarget = bpPredTarget;

    FetchTable u_fetchTable (
        .clk(clk),
        .rst(rst),
        .op(fetchOp),
        .redirect(redirect),
        .redirectFetchID(redirectFetchID),
        .comFetchID(robComFetchID),
        .imemData(imemData),
        .ready(ready),
        .stall(stall),
        .imemReq(imemReq),
        .imemAddr(imemAddr),
        .pcfWrite(pcfWrite),
        .pcfAddr(pcfAddr),
        .pcfData(pcfData),
        .outBundle(outBundle)
    );

    PCFile #(.NUM_PC_READ(NUM_PC_READ)) u_pcFile (
        .clk(clk),
        .wen(pcfWrite),
        .waddr(pcfAddr),
        .wdata(pcfData),
        .raddr(pcReadAddr),
        .rdata(pcReadData)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FetchPkg::FS_RUN;
        end else if (selBranch.taken) begin
            state <= FetchPkg::FS_RUN;
        end else if (decBranch.taken) begin
            // wfi parks the frontend until an interrupt arrives
            state <= decBranch.wfi ? FetchPkg::FS_WAIT_IRQ : FetchPkg::FS_RUN;
        end else begin
            case (state)
                FetchPkg::FS_WAIT_IRQ: begin
                    if (irqPending) begin
                        state <= FetchPkg::FS_RUN;
                    end
                end
                FetchPkg::FS_RUN: begin
                    // single interrupt block, then wait for the flush
                    if (fetchOp.valid && irqPending) begin
                        state <= FetchPkg::FS_IRQ_ISSUED;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

endmodule

// File: hdl/PCFile.sv
`timescale 1ns/1ps

module PCFile #(
    parameter int NUM_PC_READ = 2
) (
    input  logic clk,
    input  logic wen,
    input  FetchPkg::FetchID_t waddr,
    input  FetchPkg::PCFileEntry_t wdata,
    input  FetchPkg::FetchID_t raddr[NUM_PC_READ-1:0],
    output FetchPkg::PCFileEntry_t rdata[NUM_PC_READ-1:0]
);

    localparam int DEPTH = 2 ** FetchPkg::FETCH_ID_BITS;

    FetchPkg::PCFileEntry_t mem[DEPTH];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // asynchronous read ports
    always_comb begin
        for (int i = 0; i < NUM_PC_READ; i++) begin
            rdata[i] = mem[raddr[i]];
        end
    end

endmodule

// File: hdl/FetchTable.sv
`timescale 1ns/1ps

module FetchTable (
    input  logic clk,
    input  logic rst,
    FetchOpIf.tbl op,
    input  logic redirect,
    input  FetchPkg::FetchID_t redirectFetchID,
    input  FetchPkg::FetchID_t comFetchID,
    input  logic [FetchPkg::BLOCK_INSTRS*32-1:0] imemData,
    input  logic ready,
    output logic stall,
    output logic imemReq,
    output logic [31:0] imemAddr,
    output logic pcfWrite,
    output FetchPkg::FetchID_t pcfAddr,
    output FetchPkg::PCFileEntry_t pcfData,
    output FetchPkg::FetchBundle_t outBundle
);

    FetchPkg::FetchID_t nextID;
    FetchPkg::FetchID_t idSpan;
    logic windowFull;
    logic outFree;

    // block waiting for its memory data
    logic inflValid;
    FetchPkg::FetchID_t inflID;
    logic [31:0] inflPC;
    logic [31:0] inflPredTarget;
    FetchPkg::FetchOff_t inflLastValid;
    logic inflPredTaken;
    FetchPkg::FetchFault_t inflFault;

    FetchPkg::FetchBundle_t newBundle;
    FetchPkg::FetchBundle_t outReg;
    FetchPkg::FetchBundle_t skidReg;

    // at most 15 IDs outstanding
    assign idSpan = nextID - comFetchID;
    assign windowFull = &idSpan;
    assign outFree = !outReg.valid || ready;

    assign stall = (outReg.valid && skidReg.valid)
                || (outReg.valid && !ready && inflValid)
                || windowFull;

    assign imemReq = op.valid;
    assign imemAddr = op.pc;
    assign pcfWrite = op.valid;
    assign pcfAddr = nextID;
    assign pcfData = '{blockPC: op.pc, predTarget: op.predTarget};

    always_comb begin
        newBundle.valid = inflValid;
        newBundle.pc = inflPC;
        newBundle.fetchID = inflID;
        newBundle.instrs = imemData;
        newBundle.lastValid = inflLastValid;
        newBundle.predTaken = inflPredTaken;
        newBundle.predTarget = inflPredTarget;
        newBundle.fault = inflFault;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nextID <= '0;
            inflValid <= 1'b0;
            outReg.valid <= 1'b0;
            skidReg.valid <= 1'b0;
        end else if (redirect) begin
            nextID <= FetchPkg::FetchID_t'(redirectFetchID + 1'b1);
            inflValid <= 1'b0;
            outReg.valid <= 1'b0;
            skidReg.valid <= 1'b0;
        end else begin
            if (op.valid) begin
                nextID <= FetchPkg::FetchID_t'(nextID + 1'b1);
            end
            inflValid <= op.valid;
            if (outFree) begin
                if (skidReg.valid) begin
                    outReg <= skidReg;
                    skidReg <= newBundle;
                end else begin
                    outReg <= newBundle;
                end
            end else if (inflValid) begin
                // stall keeps the skid slot free for this one
                skidReg <= newBundle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            inflID <= nextID;
            inflPC <= op.pc;
            inflPredTarget <= op.predTarget;
            inflLastValid <= op.lastValid;
            inflPredTaken <= op.predTaken;
            inflFault <= op.fault;
        end
    end

    assign outBundle = outReg;

endmodule

// File: hdl/BranchPredictor.sv
`timescale 1ns/1ps

module BranchPredictor #(
    parameter int BTB_ENTRIES = 16,
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic redirect,
    input  logic [31:0] redirectPC,
    input  FetchPkg::BTUpdate_t btUpdate,
    output logic [31:0] pc,
    output logic predTaken,
    output logic [31:0] predTarget,
    output FetchPkg::FetchOff_t lastValid
);

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS = 32 - 4 - IDX_BITS;

    logic btbValid[BTB_ENTRIES];
    logic [TAG_BITS-1:0] btbTag[BTB_ENTRIES];
    logic [31:0] btbTarget[BTB_ENTRIES];
    FetchPkg::FetchOff_t btbOffs[BTB_ENTRIES];

    logic [IDX_BITS-1:0] lookupIdx;
    logic [TAG_BITS-1:0] lookupTag;
    logic [IDX_BITS-1:0] updIdx;
    logic hit;
    logic [31:0] seqPC;
    logic [31:0] nextPC;

    // block address bits select the entry
    assign lookupIdx = pc[4 +: IDX_BITS];
    assign lookupTag = pc[31 -: TAG_BITS];
    assign updIdx = btUpdate.srcPC[4 +: IDX_BITS];

    assign hit = btbValid[lookupIdx] && btbTag[lookupIdx] == lookupTag;
    assign seqPC = pc + 32'd16;

    always_comb begin
        if (hit) begin
            predTaken = 1'b1;
            predTarget = btbTarget[lookupIdx];
            lastValid = btbOffs[lookupIdx];
        end else begin
            predTaken = 1'b0;
            predTarget = seqPC;
            lastValid = FetchPkg::FetchOff_t'(FetchPkg::BLOCK_INSTRS - 1);
        end
    end

    always_comb begin
        nextPC = pc;
        if (redirect) begin
            nextPC = {redirectPC[31:4], 4'b0};
        end else if (advance) begin
            nextPC = {predTarget[31:4], 4'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPC;
        end
    end

    // valid bits need a clean start
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btbValid[i] <= 1'b0;
            end
        end else if (btUpdate.valid) begin
            btbValid[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btUpdate.valid) begin
            btbTag[updIdx] <= btUpdate.srcPC[31 -: TAG_BITS];
            btbTarget[updIdx] <= btUpdate.dstPC;
            btbOffs[updIdx] <= btUpdate.srcPC[3:2];
        end
    end

endmodule

// File: hdl/BranchSelector.sv
`timescale 1ns/1ps

module BranchSelector #(
    parameter int NUM_BRANCH_PROVS = 3
) (
    input  logic clk,
    input  logic rst,
    input  FetchPkg::BranchProv_t branches[NUM_BRANCH_PROVS-1:0],
    input  FetchPkg::SqN_t robCurSqN,
    output FetchPkg::BranchProv_t selBranch,
    output logic mispr
);

    FetchPkg::BranchProv_t oldest;
    FetchPkg::SqN_t oldestAge;

    // age is distance from the ROB head, wrapping at 64
    always_comb begin
        FetchPkg::SqN_t age;
        oldest = '0;
        oldestAge = '1;
        for (int i = 0; i < NUM_BRANCH_PROVS; i++) begin
            age = branches[i].sqN - robCurSqN;
            if (branches[i].taken && (!oldest.taken || age < oldestAge)) begin
                oldest = branches[i];
                oldestAge = age;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            selBranch.taken <= 1'b0;
        end else begin
            selBranch <= oldest;
        end
    end

    // one-cycle pulse per registered redirect
    assign mispr = selBranch.taken;

endmodule

// File: hdl/FetchOpIf.sv
`timescale 1ns/1ps

interface FetchOpIf;

    logic valid;
    logic [31:0] pc;
    FetchPkg::FetchFault_t fault;
    FetchPkg::FetchOff_t lastValid;
    logic predTaken;
    logic [31:0] predTarget;

    // fetch control side
    modport ctrl (
        output valid, pc, fault, lastValid, predTaken, predTarget
    );

    // fetch table side
    modport tbl (
        input valid, pc, fault, lastValid, predTaken, predTarget
    );

endinterface

// File: hdl/FetchPkg.sv
package FetchPkg;

    localparam int FETCH_ID_BITS = 4;
    localparam int SQN_BITS = 6;
    localparam int BLOCK_INSTRS = 4;

    typedef logic [FETCH_ID_BITS-1:0] FetchID_t;
    typedef logic [SQN_BITS-1:0] SqN_t;
    typedef logic [$clog2(BLOCK_INSTRS)-1:0] FetchOff_t;

    // marks a normal block or the fake interrupt block
    typedef enum logic {
        FF_NONE,
        FF_INTERRUPT
    } FetchFault_t;

    typedef enum logic [1:0] {
        FS_RUN,
        FS_WAIT_IRQ,
        FS_IRQ_ISSUED
    } FetchState_t;

    // branch resolved in execute
    typedef struct packed {
        logic taken;
        SqN_t sqN;
        FetchID_t fetchID;
        logic [31:0] dstPC;
    } BranchProv_t;

    typedef struct packed {
        logic taken;
        FetchID_t fetchID;
        logic [31:0] dstPC;
        logic wfi;
    } DecodeBranch_t;

    // srcPC is the address of the branch instruction itself
    typedef struct packed {
        logic valid;
        logic [31:0] srcPC;
        logic [31:0] dstPC;
    } BTUpdate_t;

    typedef struct packed {
        logic [31:0] blockPC;
        logic [31:0] predTarget;
    } PCFileEntry_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        FetchID_t fetchID;
        logic [BLOCK_INSTRS*32-1:0] instrs;
        FetchOff_t lastValid;
        logic predTaken;
        logic [31:0] predTarget;
        FetchFault_t fault;
    } FetchBundle_t;

endpackage
